//--- narrow_link.f
+incdir+.
link_pkg.sv
link_regs.sv
serializer.sv
deserializer.sv
narrow_link.sv
narrow_link_sva.sv
tb_narrow_link.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f narrow_link.f --top-module tb_narrow_link \
  -o tb_narrow_link || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_narrow_link > sim.log 2>&1
cat sim.log
grep -qx "PASS: all tests" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tb_narrow_link.sv
`include "link_config.svh"

module tb_narrow_link;

  import link_pkg::*;

  localparam int CHUNK_W        = `LINK_CHUNK_W;
  localparam int WORD_W         = `LINK_WORD_W;
  localparam int CHUNKS         = `LINK_CHUNKS;
  localparam int NUM_WORDS      = 40;
  localparam int MAX_STALL      = 8; // gap plus out_ack wait per chunk slot, generous
  localparam int TIMEOUT_CYCLES = (NUM_WORDS + 2) * (CHUNKS + 2) * MAX_STALL + 600;

  logic        clk;
  logic        reset;
  word_ch_t    in_word;
  logic        in_ack;
  word_ch_t    out_word;
  logic        out_ack;
  reg_cmd_t    reg_cmd;
  logic [31:0] rdata;
  logic        rdata_valid;

  logic [31:0]       stim_lfsr;
  logic [31:0]       ack_lfsr;   // own state, stepped only by the out_ack driver
  logic              ack_random;
  logic [WORD_W-1:0] exp_q[$];
  logic [WORD_W-1:0] exp_word;
  int                cycle;
  int                in_cycle;
  int                out_rise_cycle;
  logic              out_valid_q;
  int                words_sent;
  int                words_recv;
  int                errors;
  int                err_mark;

  narrow_link uut (
    .clk         (clk),
    .reset       (reset),
    .in_word     (in_word),
    .in_ack      (in_ack),
    .out_word    (out_word),
    .out_ack     (out_ack),
    .reg_cmd     (reg_cmd),
    .rdata       (rdata),
    .rdata_valid (rdata_valid)
  );

  always #2 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      v = {v[30:0], stim_lfsr[0]};
    end
  endtask

  // the link hands every word back unchanged, top bits included
  function automatic logic [WORD_W-1:0] ref_round_trip(input logic [WORD_W-1:0] w);
    return w;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      out_ack <= 1'b0;
    end else if (ack_random) begin
      ack_lfsr = lfsr_next(ack_lfsr);
      out_ack <= ack_lfsr[0];
    end else begin
      out_ack <= 1'b1;
    end
  end

  // input side, transfer lands on the coming edge
  always @(negedge clk) begin
    if (!reset && in_word.valid && in_ack) begin
      exp_q.push_back(ref_round_trip(in_word.data));
      in_cycle = cycle;
      words_sent++;
    end
  end

  // compare process
  always @(negedge clk) begin
    if (!reset) begin
      if (out_word.valid && !out_valid_q) out_rise_cycle = cycle;
      out_valid_q = out_word.valid;
      if (out_word.valid && out_ack) begin
        assert (exp_q.size() > 0) else begin
          errors++;
          $display("output word %h appeared with no input word pending", out_word.data);
        end
        if (exp_q.size() > 0) begin
          exp_word = exp_q.pop_front();
          assert (out_word.data == exp_word) else begin
            errors++;
            $display("ERR %0t: word %0d got %h, expected %h",
                     $time, words_recv, out_word.data, exp_word);
          end
        end
        words_recv++;
      end
    end
  end

  task automatic send_word(input logic [WORD_W-1:0] data);
    @(posedge clk);
    in_word <= '{valid: 1'b1, data: data};
    @(negedge clk);
    while (!in_ack) @(negedge clk); // transfer on the next rising edge
    @(posedge clk);
    in_word <= '0;
  endtask

  task automatic set_enable(input logic en);
    @(posedge clk);
    reg_cmd <= '{op: REG_SET_ENABLE, wdata: en};
    @(posedge clk);
    reg_cmd <= '{op: REG_NOP, wdata: 1'b0};
  endtask

  task automatic read_count(input int expected);
    @(posedge clk);
    reg_cmd <= '{op: REG_READ_COUNT, wdata: 1'b0};
    @(negedge clk);
    assert (!rdata_valid) else begin
      errors++;
      $display("rdata_valid came up in the same cycle as the read command");
    end
    @(posedge clk);
    reg_cmd <= '{op: REG_NOP, wdata: 1'b0};
    @(negedge clk);
    assert (rdata_valid) else begin
      errors++;
      $display("rdata_valid did not rise the cycle after the read command");
    end
    assert (rdata == 32'(expected)) else begin
      errors++;
      $display("ERR %0t: count read %0d, expected %0d", $time, rdata, expected);
    end
  endtask

  // link empty on both sides
  task automatic wait_drained();
    @(posedge clk);
    while (exp_q.size() != 0 || out_word.valid || in_word.valid) @(posedge clk);
  endtask

  task automatic finish_test(input int num, input string name);
    $display("test %0d %s: %s (%0d errors)", num, name,
             (errors == err_mark) ? "ok" : "failed", errors - err_mark);
    err_mark = errors;
  endtask

  // watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: no finish after %0d cycles, the link stopped moving", TIMEOUT_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    logic [31:0] r;
    int          recv_mark;
    clk            = 1'b0;
    reset          = 1'b1;
    in_word        = '0;
    out_ack        = 1'b0;
    reg_cmd        = '{op: REG_NOP, wdata: 1'b0};
    stim_lfsr      = 32'h0081_7e10;
    ack_lfsr       = 32'h0081_7e10;
    ack_random     = 1'b0;
    cycle          = 0;
    in_cycle       = 0;
    out_rise_cycle = 0;
    out_valid_q    = 1'b0;
    words_sent     = 0;
    words_recv     = 0;
    errors         = 0;
    err_mark       = 0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    @(negedge clk);
    assert (!in_ack && !out_word.valid && !rdata_valid) else begin
      errors++;
      $display("handshake outputs not all low after reset");
    end
    read_count(0);
    finish_test(1, "after reset");

    send_word(30'h2BAD_F00D);
    wait_drained();
    assert (out_rise_cycle - in_cycle == CHUNKS + 1) else begin
      errors++;
      $display("ERR %0t: latency %0d cycles, expected %0d",
               $time, out_rise_cycle - in_cycle, CHUNKS + 1);
    end
    finish_test(2, "single word");

    ack_random <= 1'b1;
    recv_mark = words_recv;
    for (int n = 0; n < NUM_WORDS; n++) begin
      rand_bits(3, r);
      repeat (r[2:0]) @(posedge clk); // input gap
      rand_bits(WORD_W, r);
      send_word(r[WORD_W-1:0]);
    end
    wait_drained();
    ack_random <= 1'b0;
    assert (words_recv - recv_mark == NUM_WORDS) else begin
      errors++;
      $display("random stream delivered %0d words instead of %0d",
               words_recv - recv_mark, NUM_WORDS);
    end
    finish_test(3, "random stream");

    set_enable(1'b0);
    recv_mark = words_recv;
    @(posedge clk);
    in_word <= '{valid: 1'b1, data: 30'h3A5C_0F1E}; // held while the link is off
    repeat (20) begin
      @(negedge clk);
      assert (!in_ack && !out_word.valid) else begin
        errors++;
        $display("link moved data while disabled");
      end
    end
    set_enable(1'b1);
    @(negedge clk);
    while (!in_ack) @(negedge clk);
    @(posedge clk);
    in_word <= '0;
    wait_drained();
    assert (words_recv - recv_mark == 1) else begin
      errors++;
      $display("pending word not delivered once after re-enable");
    end
    finish_test(4, "link disabled");

    read_count(words_recv);
    finish_test(5, "counter read");

    $display("words sent %0d, words received %0d, errors %0d", words_sent, words_recv, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- narrow_link_sva.sv
module narrow_link_sva (
  input logic               clk,
  input logic               reset,
  input link_pkg::word_ch_t in_word,
  input logic               in_ack,
  input link_pkg::word_ch_t out_word,
  input logic               out_ack
);

  // sender side holds its word until the transfer
  in_word_held: assert property (@(posedge clk) disable iff (reset)
    in_word.valid && !in_ack |=> in_word.valid && $stable(in_word.data))
    else $error("in_word dropped or changed before in_ack");

  out_word_held: assert property (@(posedge clk) disable iff (reset)
    out_word.valid && !out_ack |=> out_word.valid && $stable(out_word.data))
    else $error("out_word dropped or changed before out_ack");

  // ack only ever answers a valid word
  in_ack_needs_valid: assert property (@(posedge clk) disable iff (reset)
    in_ack |-> in_word.valid)
    else $error("in_ack high without in_word valid");

endmodule

bind narrow_link narrow_link_sva u_sva (
  .clk      (clk),
  .reset    (reset),
  .in_word  (in_word),
  .in_ack   (in_ack),
  .out_word (out_word),
  .out_ack  (out_ack)
);

//--- narrow_link.sv
module narrow_link (
  input  logic               clk,
  input  logic               reset,
  input  link_pkg::word_ch_t in_word,
  output logic               in_ack,
  output link_pkg::word_ch_t out_word,
  input  logic               out_ack,
  input  link_pkg::reg_cmd_t reg_cmd,
  output logic [31:0]        rdata,
  output logic               rdata_valid
);

  import link_pkg::*;

  chunk_ch_t link_chunk; // serializer to deserializer
  logic      link_ack;
  logic      enable;
  logic      delivered;

  // one word leaves the link
  assign delivered = out_word.valid & out_ack;

  link_regs u_regs (
    .clk         (clk),
    .reset       (reset),
    .reg_cmd     (reg_cmd),
    .delivered   (delivered),
    .enable      (enable),
    .rdata       (rdata),
    .rdata_valid (rdata_valid)
  );

  serializer u_ser (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .in_word    (in_word),
    .in_ack     (in_ack),
    .link_chunk (link_chunk),
    .link_ack   (link_ack)
  );

  deserializer u_deser (
    .clk        (clk),
    .reset      (reset),
    .link_chunk (link_chunk),
    .link_ack   (link_ack),
    .out_word   (out_word),
    .out_ack    (out_ack)
  );

endmodule

//--- deserializer.sv
`include "link_config.svh"

module deserializer (
  input  logic                clk,
  input  logic                reset,
  input  link_pkg::chunk_ch_t link_chunk,
  output logic                link_ack,
  output link_pkg::word_ch_t  out_word,
  input  logic                out_ack
);

  import link_pkg::*;

  // rebuilds a wide word from LSB-first chunks
  // chunks a, b, c arriving in that order pack as {c, b, a}

  localparam int CHUNK_W = `LINK_CHUNK_W;
  localparam int WORD_W  = `LINK_WORD_W;
  localparam int CHUNKS  = `LINK_CHUNKS;
  localparam int IDX_W   = (CHUNKS > 1) ? $clog2(CHUNKS) : 1;
  localparam int FLAT_W  = CHUNKS * CHUNK_W;

  deser_state_t state;
  deser_state_t next_state;

  logic [IDX_W-1:0] reg_idx;
  logic [IDX_W-1:0] next_idx;
  logic             take;     // chunk accepted this cycle
  logic             last_idx;

  logic [CHUNKS-1:0][CHUNK_W-1:0] chunk_reg;
  logic [FLAT_W-1:0]              chunk_flat;

  // ack whatever is offered while collecting, nothing while sending
  assign link_ack = (state == LATCH) & link_chunk.valid;
  assign take     = link_ack;
  assign last_idx = (reg_idx == IDX_W'(CHUNKS - 1));

  always_comb begin
    next_state = state;
    next_idx   = reg_idx;
    unique case (state)
      LATCH: begin
        if (take && last_idx) begin
          next_state = SEND; // last chunk lands this edge
          next_idx   = '0;
        end else if (take) begin
          next_idx = reg_idx + 1'b1;
        end
      end
      SEND: begin
        if (out_ack) begin
          next_state = LATCH;
          next_idx   = '0;
        end
      end
      default: begin
        next_state = LATCH;
        next_idx   = '0;
      end
    endcase
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state   <= LATCH;
      reg_idx <= '0;
    end else begin
      state   <= next_state;
      reg_idx <= next_idx;
    end
  end

  // write the indexed slot only, others hold
  always_ff @(posedge clk) begin
    for (int i = 0; i < CHUNKS; i++) begin
      if (take && (reg_idx == IDX_W'(i))) begin
        chunk_reg[i] <= link_chunk.data;
      end
    end
  end

  assign chunk_flat = chunk_reg;

  // data is frozen during SEND since no chunk is taken then
  assign out_word.valid = (state == SEND);
  assign out_word.data  = chunk_flat[WORD_W-1:0]; // padding bits dropped

endmodule

//--- serializer.sv
`include "link_config.svh"

module serializer (
  input  logic                clk,
  input  logic                reset,
  input  logic                enable,
  input  link_pkg::word_ch_t  in_word,
  output logic                in_ack,
  output link_pkg::chunk_ch_t link_chunk,
  input  logic                link_ack
);

  import link_pkg::*;

  localparam int CHUNK_W = `LINK_CHUNK_W;
  localparam int WORD_W  = `LINK_WORD_W;
  localparam int CHUNKS  = `LINK_CHUNKS;
  localparam int IDX_W   = (CHUNKS > 1) ? $clog2(CHUNKS) : 1;
  localparam int PAD_W   = CHUNKS * CHUNK_W;

  ser_state_t state;
  ser_state_t next_state;

  logic [IDX_W-1:0] chunk_idx;
  logic [IDX_W-1:0] next_idx;
  logic             last_chunk;
  logic             load;

  // word held while its chunks go out, LSB chunk at index 0
  logic [CHUNKS-1:0][CHUNK_W-1:0] word_reg;
  logic [PAD_W-1:0]               padded;

  // only take a word when idle and the link is switched on
  assign in_ack = (state == IDLE) & in_word.valid & enable;
  assign load   = in_ack;

  assign last_chunk = (chunk_idx == IDX_W'(CHUNKS - 1));

  // zero fill above the word so the top chunk is clean
  always_comb begin
    padded               = '0;
    padded[WORD_W-1:0]   = in_word.data;
  end

  always_comb begin
    next_state = state;
    next_idx   = chunk_idx;
    unique case (state)
      IDLE: begin
        if (load) begin
          next_state = SHIFT;
          next_idx   = '0;
        end
      end
      SHIFT: begin
        if (link_ack) begin
          if (last_chunk) begin
            next_state = IDLE; // can accept again next cycle
            next_idx   = '0;
          end else begin
            next_idx = chunk_idx + 1'b1;
          end
        end
      end
      default: begin
        next_state = IDLE;
        next_idx   = '0;
      end
    endcase
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state     <= IDLE;
      chunk_idx <= '0;
    end else begin
      state     <= next_state;
      chunk_idx <= next_idx;
    end
  end

  // payload, loaded on the accepting edge
  always_ff @(posedge clk) begin
    if (load) begin
      word_reg <= padded;
    end
  end

  // chunk 0 shows up the cycle after the word is taken
  assign link_chunk.valid = (state == SHIFT);
  assign link_chunk.data  = word_reg[chunk_idx];

endmodule

//--- link_regs.sv
module link_regs (
  input  logic               clk,
  input  logic               reset,
  input  link_pkg::reg_cmd_t reg_cmd,
  input  logic               delivered,
  output logic               enable,
  output logic [31:0]        rdata,
  output logic               rdata_valid
);

  import link_pkg::*;

  logic [31:0] count;
  logic        set_en;
  logic        rd_cnt;

  // opcode decode
  always_comb begin
    set_en = 1'b0;
    rd_cnt = 1'b0;
    unique case (reg_cmd.op)
      REG_NOP:        ;
      REG_SET_ENABLE: set_en = 1'b1;
      REG_READ_COUNT: rd_cnt = 1'b1;
      default:        ;
    endcase
  end

  // link comes up enabled
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      enable <= 1'b1;
    end else if (set_en) begin
      enable <= reg_cmd.wdata; // seen by the serializer next cycle
    end
  end

  // words handed out of the link, wraps at 2^32
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (delivered) begin
      count <= count + 32'd1;
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      rdata_valid <= 1'b0;
    end else begin
      rdata_valid <= rd_cnt;
    end
  end

  // read data one cycle after the command
  // a delivery in the same cycle shows up on the next read
  always_ff @(posedge clk) begin
    if (rd_cnt) begin
      rdata <= count;
    end
  end

endmodule

//--- link_pkg.sv
`include "link_config.svh"

package link_pkg;

  // forward half of a wide channel, ack travels on its own wire
  typedef struct packed {
    logic                    valid;
    logic [`LINK_WORD_W-1:0] data;
  } word_ch_t;

  // forward half of the narrow link
  typedef struct packed {
    logic                     valid;
    logic [`LINK_CHUNK_W-1:0] data;
  } chunk_ch_t;

  // register port opcodes
  typedef enum logic [1:0] {
    REG_NOP        = 2'd0,
    REG_SET_ENABLE = 2'd1,
    REG_READ_COUNT = 2'd2
  } reg_op_t;

  typedef struct packed {
    reg_op_t op;
    logic    wdata; // new enable value for REG_SET_ENABLE
  } reg_cmd_t;

  typedef enum logic {LATCH, SEND} deser_state_t;
  typedef enum logic {IDLE, SHIFT} ser_state_t;

endpackage

//--- link_config.svh
`ifndef LINK_CONFIG_SVH
`define LINK_CONFIG_SVH

// width of one transfer on the narrow link
`define LINK_CHUNK_W 4

// width of a wide word at either end of the link
// not a multiple of the chunk width, so the top chunk carries padding
`define LINK_WORD_W 30

// chunks per word, rounded up
`define LINK_CHUNKS ((`LINK_WORD_W + `LINK_CHUNK_W - 1) / `LINK_CHUNK_W)

`endif
